// ==== bench/virtio_mmio_stim.txt ====
# W burst(0 fixed, 1 incr) addr count word..   R addr count expected..   P recv_done pulse
# I irq   D dev_req total   Q port(0 ready, 1 desc, 2 drv, 3 dev) queue value   (hex)
R 000 4 74726976 00000002 00000001 ff001af4
R 034 1 00000040
R 100 2 ddccbbaa addeffee
R 0c0 1 00000000
W 1 014 1 00000000
R 010 1 00000020
W 1 014 1 00000001
R 010 1 00000003
R 070 1 00000000
W 1 070 1 00000004
R 070 1 00000000
W 1 070 1 00000002
R 070 1 00000002
W 1 070 1 00000004
R 070 1 00000002
W 1 070 1 00000008
R 070 1 0000000a
W 1 070 1 00000000
R 070 1 00000001
W 1 070 1 00000002
W 1 070 1 00000008
W 1 070 1 00000004
R 070 1 0000000f
W 1 030 1 00000000
W 1 080 2 11110000 11110004
W 1 090 2 22220000 22220004
W 1 0a0 2 33330000 33330004
W 1 044 1 00000001
W 1 030 1 00000001
W 1 080 1 44440000
W 0 090 3 55550001 55550002 55550003
Q 1 0 11110000
Q 2 0 22220000
Q 3 0 33330000
Q 0 0 00000001
Q 1 1 44440000
Q 2 1 55550003
Q 3 1 00000000
Q 0 1 00000000
R 044 1 00000000
W 1 030 1 00000000
R 044 1 00000001
I 0
D 0
W 1 050 1 00000000
I 1
R 060 1 00000001
D 1
W 1 064 1 00000001
I 0
R 060 1 00000000
P
I 1
R 060 1 00000001
D 2

// ==== compile.f ====
common/virtio_mmio_pkg.sv
common/reg_bus_if.sv
axi_slave/mmio_axi_slave.sv
design/virtq_regs.sv
design/device_config.sv
design/virtio_mmio_top.sv
bench/tb_virtio_mmio.sv

// ==== Bender.yml ====
package:
  name: virtio_mmio

sources:
  - common/virtio_mmio_pkg.sv
  - common/reg_bus_if.sv
  - axi_slave/mmio_axi_slave.sv
  - design/virtq_regs.sv
  - design/device_config.sv
  - design/virtio_mmio_top.sv
  - target: test
    files:
      - bench/tb_virtio_mmio.sv

// ==== bench/tb_virtio_mmio.sv ====
`timescale 1ns/1ns

module tb_virtio_mmio
	import virtio_mmio_pkg::*;
();

	localparam string STIM_FILE      = "bench/virtio_mmio_stim.txt";
	localparam int    CYCLES_PER_CMD = 200;
	localparam int    MAX_WORDS      = 4;

	logic       axi_aclk;
	logic       axi_aresetn;
	logic       awid;
	addr_t      awaddr;
	len_t       awlen;
	burst_t     awburst;
	logic       awvalid;
	logic       awready;
	data_t      wdata;
	logic       wlast;
	logic       wvalid;
	logic       wready;
	logic       bid;
	logic [1:0] bresp;
	logic       bvalid;
	logic       bready;
	logic       arid;
	addr_t      araddr;
	len_t       arlen;
	burst_t     arburst;
	logic       arvalid;
	logic       arready;
	logic       rid;
	data_t      rdata;
	logic [1:0] rresp;
	logic       rlast;
	logic       rvalid;
	logic       rready;
	logic       recv_done;
	logic       irq;
	logic       dev_req;
	data_t      q_ready   [NUM_QUEUES];
	data_t      q_desc_lo [NUM_QUEUES];
	data_t      q_drv_lo  [NUM_QUEUES];
	data_t      q_dev_lo  [NUM_QUEUES];

	// beat data for the next write, or expected words for the next read
	data_t beat_words [MAX_WORDS];
	int    cycle_count;
	int    cycle_limit;
	int    dev_req_count;
	int    error_count;
	logic  txn_id;

	virtio_mmio_top #(
		.NUM_QUEUES (NUM_QUEUES)
	) uut (
		.axi_aclk (axi_aclk), .axi_aresetn (axi_aresetn),
		.awid (awid), .awaddr (awaddr), .awlen (awlen), .awburst (awburst),
		.awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wlast (wlast), .wvalid (wvalid), .wready (wready),
		.bid (bid), .bresp (bresp), .bvalid (bvalid), .bready (bready),
		.arid (arid), .araddr (araddr), .arlen (arlen), .arburst (arburst),
		.arvalid (arvalid), .arready (arready),
		.rid (rid), .rdata (rdata), .rresp (rresp), .rlast (rlast),
		.rvalid (rvalid), .rready (rready),
		.recv_done (recv_done), .irq (irq), .dev_req (dev_req),
		.q_ready (q_ready), .q_desc_lo (q_desc_lo),
		.q_drv_lo (q_drv_lo), .q_dev_lo (q_dev_lo)
	);

	always #20 axi_aclk = ~axi_aclk;

	// dev_req is a one-cycle pulse, count every one of them
	always @(negedge axi_aclk)
	begin
		if (axi_aresetn && dev_req)
			dev_req_count <= dev_req_count + 1;
	end

	always @(posedge axi_aclk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
			report_failure($sformatf("timeout: run exceeded %0d cycles", cycle_limit));
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	task automatic report_failure(input string msg);
		error_count++;
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			report_failure($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// ------------------------------------------------------------------------
	// bus activity, all inputs change on the falling edge
	// ------------------------------------------------------------------------
	task automatic write_burst(input burst_t burst, input addr_t addr, input int count);
		int stall;
		@(negedge axi_aclk);
		awid    = txn_id;
		awaddr  = addr;
		awlen   = len_t'(count - 1);
		awburst = burst;
		awvalid = 1'b1;
		do
			@(negedge axi_aclk);
		while (!awready);
		@(negedge axi_aclk);
		awvalid = 1'b0;
		for (int i = 0; i < count; i++)
		begin
			wdata  = beat_words[i];
			wlast  = (i == count - 1);
			wvalid = 1'b1;
			while (!wready)
				@(negedge axi_aclk);
			@(negedge axi_aclk);
		end
		wvalid = 1'b0;
		wlast  = 1'b0;
		stall  = $urandom % 4;
		repeat (stall) @(negedge axi_aclk);
		bready = 1'b1;
		while (!bvalid)
			@(negedge axi_aclk);
		check_bit("bid", bid, txn_id);
		check_resp("bresp", bresp, RESP_OKAY);
		@(negedge axi_aclk);
		bready = 1'b0;
		txn_id = ~txn_id;
	endtask

	task automatic read_burst(input addr_t addr, input int count);
		int stall;
		@(negedge axi_aclk);
		arid    = txn_id;
		araddr  = addr;
		arlen   = len_t'(count - 1);
		arburst = BURST_INCR;
		arvalid = 1'b1;
		do
			@(negedge axi_aclk);
		while (!arready);
		@(negedge axi_aclk);
		arvalid = 1'b0;
		for (int i = 0; i < count; i++)
		begin
			// hold rready low for a while, rvalid has to wait
			stall = $urandom % 4;
			repeat (stall) @(negedge axi_aclk);
			rready = 1'b1;
			while (!rvalid)
				@(negedge axi_aclk);
			check_data($sformatf("rdata beat %0d at %h", i, addr), rdata, beat_words[i]);
			check_resp("rresp", rresp, RESP_OKAY);
			check_bit("rid", rid, txn_id);
			check_bit("rlast", rlast, i == count - 1);
			@(negedge axi_aclk);
			rready = 1'b0;
		end
		txn_id = ~txn_id;
	endtask

	task automatic pulse_recv_done();
		@(negedge axi_aclk);
		recv_done = 1'b1;
		@(negedge axi_aclk);
		recv_done = 1'b0;
	endtask

	// 0 ready, 1 descriptor, 2 driver area, 3 device area
	function automatic data_t queue_port(input int field, input int q);
		case (field)
			0:       return q_ready[q];
			1:       return q_desc_lo[q];
			2:       return q_drv_lo[q];
			default: return q_dev_lo[q];
		endcase
	endfunction

	function automatic bit is_command_line(input string line);
		if (line.len() == 0)
			return 1'b0;
		return line.getc(0) != "#" && line.getc(0) != "\n" && line.getc(0) != " ";
	endfunction

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		int          fd;
		int          num_cmds;
		string       line;
		logic [7:0]  op;
		logic [31:0] f0, f1, f2, f3, f4, f5, f6;
		axi_aclk    = 1'b0;
		axi_aresetn = 1'b0;
		awid        = 1'b0;
		awaddr      = '0;
		awlen       = '0;
		awburst     = BURST_INCR;
		awvalid     = 1'b0;
		wdata       = '0;
		wlast       = 1'b0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		arid        = 1'b0;
		araddr      = '0;
		arlen       = '0;
		arburst     = BURST_INCR;
		arvalid     = 1'b0;
		rready      = 1'b0;
		recv_done   = 1'b0;
		txn_id      = 1'b0;
		void'($urandom(8));

		// first pass only sizes the timeout
		num_cmds = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
			report_failure({"cannot open the stimulus file ", STIM_FILE});
		while ($fgets(line, fd) != 0)
		begin
			if (is_command_line(line))
				num_cmds++;
		end
		$fclose(fd);
		cycle_limit = (num_cmds + 1) * CYCLES_PER_CMD;

		repeat (8) @(negedge axi_aclk);
		axi_aresetn = 1'b1;

		fd = $fopen(STIM_FILE, "r");
		while ($fgets(line, fd) != 0)
		begin
			if (is_command_line(line))
			begin
				void'($sscanf(line, "%c %h %h %h %h %h %h %h", op, f0, f1, f2, f3, f4, f5, f6));
				case (op)
					"W":
					begin
						beat_words = '{f3, f4, f5, f6};
						write_burst(burst_t'(f0), addr_t'(f1), f2);
					end
					"R":
					begin
						beat_words = '{f2, f3, f4, f5};
						read_burst(addr_t'(f0), f1);
					end
					"P": pulse_recv_done();
					"I": check_bit("irq", irq, f0[0]);
					"D": check_data("dev_req count", data_t'(dev_req_count), f0);
					"Q": check_data($sformatf("queue %0d port %0d", f1, f0),
						queue_port(f0, f1), f2);
					default: report_failure({"unknown command in stimulus file: ", line});
				endcase
			end
		end
		$fclose(fd);

		repeat (4) @(negedge axi_aclk);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== design/virtio_mmio_top.sv ====
`timescale 1ns/1ns

module virtio_mmio_top
	import virtio_mmio_pkg::*;
#(
	parameter int NUM_QUEUES = virtio_mmio_pkg::NUM_QUEUES
)
(
	input  logic       axi_aclk,
	input  logic       axi_aresetn,
	// AXI4 slave
	input  logic       awid,
	input  addr_t      awaddr,
	input  len_t       awlen,
	input  burst_t     awburst,
	input  logic       awvalid,
	output logic       awready,
	input  data_t      wdata,
	input  logic       wlast,
	input  logic       wvalid,
	output logic       wready,
	output logic       bid,
	output logic [1:0] bresp,
	output logic       bvalid,
	input  logic       bready,
	input  logic       arid,
	input  addr_t      araddr,
	input  len_t       arlen,
	input  burst_t     arburst,
	input  logic       arvalid,
	output logic       arready,
	output logic       rid,
	output data_t      rdata,
	output logic [1:0] rresp,
	output logic       rlast,
	output logic       rvalid,
	input  logic       rready,
	// device side
	input  logic       recv_done,
	output logic       irq,
	output logic       dev_req,
	output data_t      q_ready   [NUM_QUEUES],
	output data_t      q_desc_lo [NUM_QUEUES],
	output data_t      q_drv_lo  [NUM_QUEUES],
	output data_t      q_dev_lo  [NUM_QUEUES]
);

	reg_bus_if bus ();
	qsel_t     queue_sel;

	mmio_axi_slave u_axi_slave (
		.axi_aclk    (axi_aclk),
		.axi_aresetn (axi_aresetn),
		.awid        (awid),
		.awaddr      (awaddr),
		.awlen       (awlen),
		.awburst     (awburst),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wlast       (wlast),
		.wvalid      (wvalid),
		.wready      (wready),
		.bid         (bid),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.arid        (arid),
		.araddr      (araddr),
		.arlen       (arlen),
		.arburst     (arburst),
		.arvalid     (arvalid),
		.arready     (arready),
		.rid         (rid),
		.rdata       (rdata),
		.rresp       (rresp),
		.rlast       (rlast),
		.rvalid      (rvalid),
		.rready      (rready),
		.bus         (bus.slave)
	);

	// one register block per virtqueue, 0 receive and 1 send
	for (genvar q = 0; q < NUM_QUEUES; q++)
	begin : g_queue
		virtq_regs #(
			.QUEUE_INDEX (q)
		) u_virtq_regs (
			.axi_aclk    (axi_aclk),
			.axi_aresetn (axi_aresetn),
			.bus         (bus.regs),
			.queue_sel   (queue_sel),
			.ready       (q_ready[q]),
			.desc_lo     (q_desc_lo[q]),
			.drv_lo      (q_drv_lo[q]),
			.dev_lo      (q_dev_lo[q])
		);
	end

	device_config #(
		.NUM_QUEUES (NUM_QUEUES)
	) u_device_config (
		.axi_aclk    (axi_aclk),
		.axi_aresetn (axi_aresetn),
		.bus         (bus.reader),
		.queue_ready (q_ready),
		.recv_done   (recv_done),
		.queue_sel   (queue_sel),
		.irq         (irq),
		.dev_req     (dev_req)
	);

endmodule

// ==== design/device_config.sv ====
`timescale 1ns/1ns

module device_config
	import virtio_mmio_pkg::*;
#(
	parameter int NUM_QUEUES = virtio_mmio_pkg::NUM_QUEUES
)
(
	input  logic  axi_aclk,
	input  logic  axi_aresetn,
	reg_bus_if.reader bus,
	input  data_t queue_ready [NUM_QUEUES],
	input  logic  recv_done,
	output qsel_t queue_sel,
	output logic  irq,
	output logic  dev_req
);

	data_t      feat_sel_q;
	qsel_t      queue_sel_q;
	data_t      status_q;
	data_t      status_wr_q;
	logic       status_pend_q;
	dev_state_t state_q;
	data_t      int_status_q;
	data_t      int_next;
	logic       int_d1_q;
	logic       int_d2_q;
	data_t      rd_word;
	data_t      rd_data_q;

	// -------------------------------------------------------------------------
	// plain write registers
	// -------------------------------------------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			feat_sel_q    <= '0;
			queue_sel_q   <= '0;
			status_pend_q <= 1'b0;
		end
		else
		begin
			status_pend_q <= bus.wr_en && (bus.wr_addr == REG_STATUS);
			if (bus.wr_en && bus.wr_addr == REG_DEV_FEAT_SEL)
				feat_sel_q <= bus.wr_data;
			if (bus.wr_en && bus.wr_addr == REG_QUEUE_SEL)
				queue_sel_q <= qsel_t'(bus.wr_data[$bits(qsel_t)-1:0]);
		end
	end

	// status value is held one cycle before the rules see it
	always_ff @(posedge axi_aclk)
	begin
		if (bus.wr_en && bus.wr_addr == REG_STATUS)
			status_wr_q <= bus.wr_data;
	end

	// -------------------------------------------------------------------------
	// device status handshake
	// -------------------------------------------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			status_q <= '0;
			state_q  <= ST_RESET;
		end
		else if (status_pend_q)
		begin
			if (status_wr_q == '0)
			begin
				// acknowledge only, start over
				status_q <= data_t'(1);
				state_q  <= ST_RESET;
			end
			else
			begin
				case (state_q)
					ST_RESET:
						if (status_wr_q[STAT_DRIVER])
						begin
							status_q[STAT_DRIVER] <= 1'b1;
							state_q <= ST_SETUP_BASE;
						end
					ST_SETUP_BASE:
						if (status_wr_q[STAT_FEATURES_OK])
						begin
							status_q[STAT_FEATURES_OK] <= 1'b1;
							state_q <= ST_SETUP_DRIVER;
						end
					ST_SETUP_DRIVER:
						if (status_wr_q[STAT_DRIVER_OK])
						begin
							status_q[STAT_DRIVER_OK] <= 1'b1;
							state_q <= ST_IDLE;
						end
					default:
						;
				endcase
			end
		end
	end

	// -------------------------------------------------------------------------
	// interrupt status
	// -------------------------------------------------------------------------
	always_comb
	begin
		int_next = int_status_q;
		if (bus.wr_en && bus.wr_addr == REG_INT_ACK)
			int_next = int_status_q & ~bus.wr_data;
		// a new event is never lost to a same-cycle ack
		if ((bus.wr_en && bus.wr_addr == REG_QUEUE_NOTIFY) || recv_done)
			int_next[0] = 1'b1;
	end

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			int_status_q <= '0;
			int_d1_q     <= 1'b0;
			int_d2_q     <= 1'b0;
		end
		else
		begin
			int_status_q <= int_next;
			int_d1_q     <= int_status_q[0];
			int_d2_q     <= int_d1_q;
		end
	end

	assign irq     = int_status_q[0];
	assign dev_req = int_d1_q && !int_d2_q;

	// -------------------------------------------------------------------------
	// read data
	// -------------------------------------------------------------------------
	always_comb
	begin
		case (bus.rd_addr)
			REG_MAGIC:         rd_word = MAGIC_VALUE;
			REG_VERSION:       rd_word = VERSION;
			REG_DEVICE_ID:     rd_word = DEVICE_ID;
			REG_VENDOR_ID:     rd_word = VENDOR_ID;
			REG_DEV_FEAT:      rd_word = (feat_sel_q == '0) ? DEVICE_FEATURES[31:0] :
				DEVICE_FEATURES[63:32];
			REG_QUEUE_NUM_MAX: rd_word = QUEUE_NUM_MAX;
			REG_QUEUE_READY:   rd_word = queue_ready[queue_sel_q];
			REG_INT_STATUS:    rd_word = int_status_q;
			REG_STATUS:        rd_word = status_q;
			// config space never changes
			REG_CFG_GEN:       rd_word = '0;
			REG_MAC_LO:        rd_word = MAC_LO_WORD;
			REG_MAC_HI:        rd_word = MAC_HI_WORD;
			default:           rd_word = '0;
		endcase
	end

	always_ff @(posedge axi_aclk)
	begin
		if (bus.rd_en)
			rd_data_q <= rd_word;
	end

	assign bus.rd_data = rd_data_q;
	assign queue_sel   = queue_sel_q;

endmodule

// ==== design/virtq_regs.sv ====
`timescale 1ns/1ns

module virtq_regs
	import virtio_mmio_pkg::*;
#(
	parameter int QUEUE_INDEX = 0
)
(
	input  logic  axi_aclk,
	input  logic  axi_aresetn,
	reg_bus_if.regs bus,
	input  qsel_t queue_sel,
	output data_t ready,
	output data_t desc_lo,
	output data_t drv_lo,
	output data_t dev_lo
);

	// descriptor, driver and device areas, each low word then high word
	data_t addr_words [6];
	data_t ready_q;
	logic  sel_wr;

	assign sel_wr = bus.wr_en && (queue_sel == qsel_t'(QUEUE_INDEX));

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			ready_q    <= '0;
			addr_words <= '{default: '0};
		end
		else if (sel_wr)
		begin
			case (bus.wr_addr)
				REG_QUEUE_READY: ready_q       <= bus.wr_data;
				REG_DESC_LO:     addr_words[0] <= bus.wr_data;
				REG_DESC_HI:     addr_words[1] <= bus.wr_data;
				REG_DRV_LO:      addr_words[2] <= bus.wr_data;
				REG_DRV_HI:      addr_words[3] <= bus.wr_data;
				REG_DEV_LO:      addr_words[4] <= bus.wr_data;
				REG_DEV_HI:      addr_words[5] <= bus.wr_data;
				default:         ;
			endcase
		end
	end

	// only the low halves leave the block
	assign ready   = ready_q;
	assign desc_lo = addr_words[0];
	assign drv_lo  = addr_words[2];
	assign dev_lo  = addr_words[4];

endmodule

// ==== axi_slave/mmio_axi_slave.sv ====
`timescale 1ns/1ns

module mmio_axi_slave
	import virtio_mmio_pkg::*;
(
	input  logic   axi_aclk,
	input  logic   axi_aresetn,
	// write address channel
	input  logic   awid,
	input  addr_t  awaddr,
	input  len_t   awlen,
	input  burst_t awburst,
	input  logic   awvalid,
	output logic   awready,
	// write data channel
	input  data_t  wdata,
	input  logic   wlast,
	input  logic   wvalid,
	output logic   wready,
	// write response channel
	output logic   bid,
	output logic [1:0] bresp,
	output logic   bvalid,
	input  logic   bready,
	// read address channel
	input  logic   arid,
	input  addr_t  araddr,
	input  len_t   arlen,
	input  burst_t arburst,
	input  logic   arvalid,
	output logic   arready,
	// read data channel
	output logic   rid,
	output data_t  rdata,
	output logic [1:0] rresp,
	output logic   rlast,
	output logic   rvalid,
	input  logic   rready,
	reg_bus_if.slave bus
);

	typedef enum logic [2:0] {
		SL_IDLE,
		SL_WDATA,
		SL_WRESP,
		SL_RISSUE,
		SL_RDATA
	} slave_state_t;

	slave_state_t state_q;
	addr_t        addr_q;
	addr_t        next_addr;
	len_t         len_q;
	len_t         cnt_q;
	burst_t       burst_q;
	logic         id_q;
	logic         wr_beat;
	logic         last_beat;

	assign wr_beat   = wready && wvalid;
	assign last_beat = (cnt_q == len_q);

	// fixed bursts stay put, anything else steps one word
	assign next_addr = (burst_q == BURST_FIXED) ? addr_q :
		{addr_q[$bits(addr_t)-1:2] + 1'b1, 2'b00};

	// -------------------------------------------------------------------------
	// one transaction at a time
	// -------------------------------------------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			state_q <= SL_IDLE;
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			arready <= 1'b0;
			rvalid  <= 1'b0;
			addr_q  <= '0;
			len_q   <= '0;
			cnt_q   <= '0;
			burst_q <= BURST_INCR;
			id_q    <= 1'b0;
		end
		else
		begin
			awready <= 1'b0;
			arready <= 1'b0;
			case (state_q)
				SL_IDLE:
				begin
					// write wins when both arrive together
					if (awvalid)
					begin
						awready <= 1'b1;
						addr_q  <= awaddr;
						len_q   <= awlen;
						burst_q <= awburst;
						id_q    <= awid;
						cnt_q   <= '0;
						state_q <= SL_WDATA;
					end
					else if (arvalid)
					begin
						arready <= 1'b1;
						addr_q  <= araddr;
						len_q   <= arlen;
						burst_q <= arburst;
						id_q    <= arid;
						cnt_q   <= '0;
						state_q <= SL_RISSUE;
					end
				end
				SL_WDATA:
				begin
					if (!wready && wvalid)
						wready <= 1'b1;
					if (wr_beat)
					begin
						cnt_q  <= cnt_q + 1'b1;
						addr_q <= next_addr;
						// close on wlast, or on the beat count as a fallback
						if (wlast || last_beat)
						begin
							wready  <= 1'b0;
							bvalid  <= 1'b1;
							state_q <= SL_WRESP;
						end
					end
				end
				SL_WRESP:
				begin
					if (bready)
					begin
						bvalid  <= 1'b0;
						state_q <= SL_IDLE;
					end
				end
				SL_RISSUE:
				begin
					// rd_data is registered on this edge
					rvalid  <= 1'b1;
					state_q <= SL_RDATA;
				end
				SL_RDATA:
				begin
					if (rready)
					begin
						rvalid <= 1'b0;
						if (last_beat)
							state_q <= SL_IDLE;
						else
						begin
							cnt_q   <= cnt_q + 1'b1;
							addr_q  <= next_addr;
							state_q <= SL_RISSUE;
						end
					end
				end
				default:
					state_q <= SL_IDLE;
			endcase
		end
	end

	// -------------------------------------------------------------------------
	// register bus and responses
	// -------------------------------------------------------------------------
	assign bus.wr_en   = wr_beat;
	assign bus.wr_addr = addr_q;
	assign bus.wr_data = wdata;
	assign bus.rd_en   = (state_q == SL_RISSUE);
	assign bus.rd_addr = addr_q;

	assign bid   = id_q;
	assign bresp = RESP_OKAY;
	assign rid   = id_q;
	assign rdata = bus.rd_data;
	assign rresp = RESP_OKAY;
	assign rlast = rvalid && last_beat;

endmodule

// ==== common/reg_bus_if.sv ====
`timescale 1ns/1ns

interface reg_bus_if
	import virtio_mmio_pkg::*;
();

	logic  wr_en;
	addr_t wr_addr;
	data_t wr_data;
	logic  rd_en;
	addr_t rd_addr;
	data_t rd_data;

	modport slave (
		output wr_en, wr_addr, wr_data, rd_en, rd_addr,
		input  rd_data
	);

	modport regs (
		input wr_en, wr_addr, wr_data
	);

	// the config block also decodes writes
	modport reader (
		input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
		output rd_data
	);

endinterface

// ==== common/virtio_mmio_pkg.sv ====
package virtio_mmio_pkg;

	// -------------------------------------------------------------------------
	// widths
	// -------------------------------------------------------------------------
	typedef logic [11:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic        qsel_t;
	typedef logic [1:0]  burst_t;
	typedef logic [7:0]  len_t;

	localparam burst_t     BURST_FIXED = 2'b00;
	localparam burst_t     BURST_INCR  = 2'b01;
	localparam logic [1:0] RESP_OKAY   = 2'b00;

	// receive and send
	localparam int NUM_QUEUES = 2;

	// driver handshake progress
	typedef enum logic [1:0] {
		ST_RESET,
		ST_SETUP_BASE,
		ST_SETUP_DRIVER,
		ST_IDLE
	} dev_state_t;

	// -------------------------------------------------------------------------
	// register map
	// -------------------------------------------------------------------------
	localparam addr_t REG_MAGIC         = 12'h000;
	localparam addr_t REG_VERSION       = 12'h004;
	localparam addr_t REG_DEVICE_ID     = 12'h008;
	localparam addr_t REG_VENDOR_ID     = 12'h00C;
	localparam addr_t REG_DEV_FEAT      = 12'h010;
	localparam addr_t REG_DEV_FEAT_SEL  = 12'h014;
	localparam addr_t REG_QUEUE_SEL     = 12'h030;
	localparam addr_t REG_QUEUE_NUM_MAX = 12'h034;
	localparam addr_t REG_QUEUE_READY   = 12'h044;
	localparam addr_t REG_QUEUE_NOTIFY  = 12'h050;
	localparam addr_t REG_INT_STATUS    = 12'h060;
	localparam addr_t REG_INT_ACK       = 12'h064;
	localparam addr_t REG_STATUS        = 12'h070;
	localparam addr_t REG_DESC_LO       = 12'h080;
	localparam addr_t REG_DESC_HI       = 12'h084;
	localparam addr_t REG_DRV_LO        = 12'h090;
	localparam addr_t REG_DRV_HI        = 12'h094;
	localparam addr_t REG_DEV_LO        = 12'h0A0;
	localparam addr_t REG_DEV_HI        = 12'h0A4;
	localparam addr_t REG_CFG_GEN       = 12'h0FC;
	localparam addr_t REG_MAC_LO        = 12'h100;
	localparam addr_t REG_MAC_HI        = 12'h104;

	// -------------------------------------------------------------------------
	// identification
	// -------------------------------------------------------------------------
	localparam data_t MAGIC_VALUE   = 32'h74726976;
	localparam data_t VERSION       = 32'h2;
	localparam data_t DEVICE_ID     = 32'h1;
	localparam data_t VENDOR_ID     = 32'hFF001AF4;
	localparam data_t QUEUE_NUM_MAX = 32'h40;

	// access platform (33), version 1 (32), net mac (5)
	localparam logic [63:0] DEVICE_FEATURES = (64'd1 << 33) | (64'd1 << 32) | (64'd1 << 5);

	localparam logic [47:0] MAC_ADDR = 48'haabbccddeeff;
	localparam data_t MAC_LO_WORD = {MAC_ADDR[23:16], MAC_ADDR[31:24],
		MAC_ADDR[39:32], MAC_ADDR[47:40]};
	localparam data_t MAC_HI_WORD = {8'hAD, 8'hDE, MAC_ADDR[7:0], MAC_ADDR[15:8]};

	// device status bits set by the driver
	localparam int STAT_DRIVER      = 1;
	localparam int STAT_DRIVER_OK   = 2;
	localparam int STAT_FEATURES_OK = 3;

endpackage
